/* wb_bus_pkg.sv */
package wb_bus_pkg;

    // ==================================================
    // wishbone bus widths
    // ==================================================

    // byte addressed bus carrying one 32 bit word per beat
    localparam int WB_ADR_W = 32;
    localparam int WB_DAT_W = 32;

    // one select line for every byte lane of a data word
    localparam int WB_SEL_W = WB_DAT_W / 8;

    // ==================================================
    // bus side types
    // ==================================================

    // byte lane select, bit n enables bits 8n+7 to 8n of the data word
    typedef logic [WB_SEL_W-1:0] wb_sel_t;

    // states of the bus cycle machine
    // a line fill walks through the three burst states and
    // ends in wait_ack, where the fourth ack closes the cycle
    // single reads and writes go straight from idle to wait_ack
    typedef enum logic [2:0]
    {
        WB_IDLE     = 3'd0,
        WB_BURST_1  = 3'd1,
        WB_BURST_2  = 3'd2,
        WB_BURST_3  = 3'd3,
        WB_WAIT_ACK = 3'd4
    } wb_state_t;

endpackage

/* cache_req_pkg.sv */
package cache_req_pkg;

    // the command carries bus fields, so the bus widths are needed here
    import wb_bus_pkg::*;

    // ==================================================
    // requester side constants
    // ==================================================

    // words in one cache line fill
    localparam int BURST_WORDS = 4;

    // instruction port and data port
    localparam int NUM_PORTS = 2;

    // ==================================================
    // requester side types
    // ==================================================

    // which cache port owns an access
    // the value doubles as an index into per port flag vectors
    typedef enum logic
    {
        PORT_I = 1'b0,
        PORT_D = 1'b1
    } req_port_t;

    // one registered bus command, handed from the arbiter to the bus FSM
    // valid is high for a single cycle per command
    // qword is only ever set for reads
    typedef struct packed
    {
        logic                valid;
        req_port_t           port;
        logic                write;
        logic                qword;
        logic [WB_ADR_W-1:0] address;
        logic [WB_DAT_W-1:0] wdata;
        wb_sel_t             sel;
    } bus_cmd_t;

endpackage

/* wb_req_decode.sv */
module wb_req_decode
    import wb_bus_pkg::*;
    import cache_req_pkg::*;
(
    input  logic                i_clk,
    input  logic                quick_n_reset,
    input  logic                i_ireq,
    input  logic                i_iqword,
    input  logic [WB_ADR_W-1:0] i_iaddr,
    input  logic                i_dreq,
    input  logic                i_dwrite,
    input  logic                i_dqword,
    input  logic [WB_ADR_W-1:0] i_daddr,
    input  logic [WB_DAT_W-1:0] i_dwdata,
    input  wb_sel_t             i_dsel,
    input  logic                i_busy,
    input  logic                i_ipending_clear,
    input  logic                i_dpending_clear,
    output bus_cmd_t            o_cmd
);

    // set once a port's request has been turned into a command
    // it stays set until that port's done has dropped again
    logic [NUM_PORTS-1:0] served_q;

    logic take_d;
    logic take_i;
    logic can_load;
    logic load;

    // byte enables of a write give the two low address bits
    // single lanes map to their lane number, the halves to 0 or 2
    function automatic logic [1:0] sel_to_lsb(input wb_sel_t sel);
        logic [1:0] lsb;
        begin
            case (sel)
                4'b0001: lsb = 2'd0;
                4'b0010: lsb = 2'd1;
                4'b0100: lsb = 2'd2;
                4'b1000: lsb = 2'd3;
                4'b0011: lsb = 2'd0;
                4'b1100: lsb = 2'd2;
                default: lsb = 2'd0;
            endcase
            return lsb;
        end
    endfunction

    // a request counts only while its port has not yet been served
    assign take_d = i_dreq && !served_q[PORT_D];
    assign take_i = i_ireq && !served_q[PORT_I];

    // while valid is out, the bus FSM has not raised busy yet,
    // so the pending command itself also blocks a new one
    assign can_load = !i_busy && !o_cmd.valid;
    assign load     = can_load && (take_d || take_i);

    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            o_cmd.valid <= 1'b0;
            served_q    <= '0;
        end
        else
        begin
            o_cmd.valid <= load;

            // data port wins when both ports ask in the same cycle
            if (can_load && take_d)
                served_q[PORT_D] <= 1'b1;
            else if (i_dpending_clear)
                served_q[PORT_D] <= 1'b0;

            if (can_load && !take_d && take_i)
                served_q[PORT_I] <= 1'b1;
            else if (i_ipending_clear)
                served_q[PORT_I] <= 1'b0;
        end

        // command payload follows the winning port
        if (load)
        begin
            if (take_d)
            begin
                o_cmd.port    <= PORT_D;
                o_cmd.write   <= i_dwrite;
                o_cmd.qword   <= i_dqword && !i_dwrite;
                o_cmd.address <= {i_daddr[WB_ADR_W-1:2],
                                  i_dwrite ? sel_to_lsb(i_dsel) : 2'b00};
                o_cmd.wdata   <= i_dwdata;
                o_cmd.sel     <= i_dwrite ? i_dsel : '1;
            end
            else
            begin
                // instruction fetches are always word aligned reads
                o_cmd.port    <= PORT_I;
                o_cmd.write   <= 1'b0;
                o_cmd.qword   <= i_iqword;
                o_cmd.address <= {i_iaddr[WB_ADR_W-1:2], 2'b00};
                o_cmd.wdata   <= '0;
                o_cmd.sel     <= '1;
            end
        end
    end

    // a command is only issued while the bus FSM is free
    a_valid_not_busy : assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        $rose(o_cmd.valid) |-> !i_busy);

    // the bus FSM picks up every command on the next edge
    a_valid_taken : assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        o_cmd.valid |=> (i_busy && !o_cmd.valid));

endmodule

/* wb_bus_execute.sv */
module wb_bus_execute
    import wb_bus_pkg::*;
    import cache_req_pkg::*;
(
    input  logic                i_clk,
    input  logic                quick_n_reset,
    input  bus_cmd_t            i_cmd,
    input  logic                i_wb_ack,
    input  logic [WB_DAT_W-1:0] i_wb_dat,
    output logic                o_busy,
    output req_port_t           o_port,
    output logic                o_word_ack,
    output logic                o_last_ack,
    output logic [WB_DAT_W-1:0] o_rdata,
    output logic [WB_ADR_W-1:0] o_wb_adr,
    output wb_sel_t             o_wb_sel,
    output logic                o_wb_we,
    output logic [WB_DAT_W-1:0] o_wb_dat,
    output logic                o_wb_cyc,
    output logic                o_wb_stb
);

    // address bits that step through a line, just above the byte offset
    localparam int WRAP_W = $clog2(BURST_WORDS);

    wb_state_t state_q;

    logic bus_ack;
    logic in_burst;

    // an ack only counts while a strobe is out
    assign bus_ack  = i_wb_ack && o_wb_stb;
    assign in_burst = (state_q == WB_BURST_1) || (state_q == WB_BURST_2)
                   || (state_q == WB_BURST_3);

    // read data goes straight through, qualified by the word ack
    assign o_word_ack = bus_ack && !o_wb_we;
    assign o_last_ack = bus_ack && (state_q == WB_WAIT_ACK);
    assign o_rdata    = i_wb_dat;

    // ==================================================
    // bus cycle FSM
    // ==================================================

    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            state_q  <= WB_IDLE;
            o_busy   <= 1'b0;
            o_wb_cyc <= 1'b0;
            o_wb_stb <= 1'b0;
            o_wb_we  <= 1'b0;
        end
        else
        begin
            case (state_q)
                WB_IDLE:
                begin
                    // start the cycle on the edge that sees the command
                    if (i_cmd.valid)
                    begin
                        o_busy   <= 1'b1;
                        o_wb_cyc <= 1'b1;
                        o_wb_stb <= 1'b1;
                        o_wb_we  <= i_cmd.write;
                        if (i_cmd.qword && !i_cmd.write)
                            state_q <= WB_BURST_1;
                        else
                            state_q <= WB_WAIT_ACK;
                    end
                end
                WB_BURST_1:
                begin
                    if (bus_ack)
                        state_q <= WB_BURST_2;
                end
                WB_BURST_2:
                begin
                    if (bus_ack)
                        state_q <= WB_BURST_3;
                end
                WB_BURST_3:
                begin
                    if (bus_ack)
                        state_q <= WB_WAIT_ACK;
                end
                WB_WAIT_ACK:
                begin
                    // final ack closes the cycle and frees the arbiter
                    if (bus_ack)
                    begin
                        state_q  <= WB_IDLE;
                        o_busy   <= 1'b0;
                        o_wb_cyc <= 1'b0;
                        o_wb_stb <= 1'b0;
                        o_wb_we  <= 1'b0;
                    end
                end
                default:
                begin
                    state_q <= WB_IDLE;
                end
            endcase
        end

        // bus payload is held steady until each ack
        if (state_q == WB_IDLE && i_cmd.valid)
        begin
            o_wb_adr <= i_cmd.address;
            o_wb_sel <= i_cmd.sel;
            o_wb_dat <= i_cmd.wdata;
            o_port   <= i_cmd.port;
        end
        else if (in_burst && bus_ack)
        begin
            // next word of the line, wrapping inside the line
            o_wb_adr[2 +: WRAP_W] <= o_wb_adr[2 +: WRAP_W] + WRAP_W'(1);
        end
    end

    a_idle_next : assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        state_q == WB_IDLE |=> state_q inside {WB_IDLE, WB_BURST_1, WB_WAIT_ACK});

    // each burst ack moves exactly one step towards the final word
    a_burst_1 : assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (state_q == WB_BURST_1 && i_wb_ack) |=> state_q == WB_BURST_2);
    a_burst_2 : assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (state_q == WB_BURST_2 && i_wb_ack) |=> state_q == WB_BURST_3);
    a_burst_3 : assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (state_q == WB_BURST_3 && i_wb_ack) |=> state_q == WB_WAIT_ACK);

    a_wait_ack : assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (state_q == WB_WAIT_ACK && i_wb_ack) |=> state_q == WB_IDLE);

endmodule

/* wb_resp_route.sv */
module wb_resp_route
    import wb_bus_pkg::*;
    import cache_req_pkg::*;
(
    input  logic                i_clk,
    input  logic                quick_n_reset,
    input  req_port_t           i_port,
    input  logic                i_word_ack,
    input  logic                i_last_ack,
    input  logic [WB_DAT_W-1:0] i_rdata,
    input  logic                i_ireq,
    input  logic                i_dreq,
    output logic                o_irvalid,
    output logic [WB_DAT_W-1:0] o_irdata,
    output logic                o_idone,
    output logic                o_drvalid,
    output logic [WB_DAT_W-1:0] o_drdata,
    output logic                o_ddone,
    output logic                o_ipending_clear,
    output logic                o_dpending_clear
);

    // done level per port, indexed by req_port_t
    logic [NUM_PORTS-1:0] done_q;
    logic [NUM_PORTS-1:0] req_vec;

    assign req_vec = {i_dreq, i_ireq};

    // done rises after the last ack and holds until the request drops
    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            done_q <= '0;
        end
        else
        begin
            for (int p = 0; p < NUM_PORTS; p++)
            begin
                if (i_last_ack && i_port == req_port_t'(p))
                    done_q[p] <= 1'b1;
                else if (done_q[p] && !req_vec[p])
                    done_q[p] <= 1'b0;
            end
        end
    end

    // read words go only to the port that owns the access
    assign o_irvalid = i_word_ack && (i_port == PORT_I);
    assign o_drvalid = i_word_ack && (i_port == PORT_D);
    assign o_irdata  = i_rdata;
    assign o_drdata  = i_rdata;

    assign o_idone = done_q[PORT_I];
    assign o_ddone = done_q[PORT_D];

    // high in the cycle before done drops, so the served flag
    // in the arbiter clears on the same edge as done
    assign o_ipending_clear = done_q[PORT_I] && !i_ireq;
    assign o_dpending_clear = done_q[PORT_D] && !i_dreq;

endmodule

/* wb_master.sv */
module wb_master
    import cache_req_pkg::*;
(
    input  logic        i_clk,
    input  logic        quick_n_reset,

    // instruction cache port
    input  logic        i_icache_req,
    input  logic        i_icache_qword,
    input  logic [31:0] i_icache_address,
    output logic        o_icache_rvalid,
    output logic [31:0] o_icache_read_data,
    output logic        o_icache_done,

    // data cache port
    input  logic        i_dcache_req,
    input  logic        i_dcache_write,
    input  logic        i_dcache_qword,
    input  logic [31:0] i_dcache_address,
    input  logic [31:0] i_dcache_write_data,
    input  logic [3:0]  i_dcache_byte_enable,
    output logic        o_dcache_rvalid,
    output logic [31:0] o_dcache_read_data,
    output logic        o_dcache_done,

    // wishbone master side
    output logic [31:0] o_wb_adr,
    output logic [3:0]  o_wb_sel,
    output logic        o_wb_we,
    output logic [31:0] o_wb_dat,
    output logic        o_wb_cyc,
    output logic        o_wb_stb,
    input  logic [31:0] i_wb_dat,
    input  logic        i_wb_ack
);

    bus_cmd_t    cmd;
    req_port_t   port;
    logic        busy;
    logic        word_ack;
    logic        last_ack;
    logic [31:0] rdata;
    logic        ipending_clear;
    logic        dpending_clear;

    // arbiter and command register
    wb_req_decode u_decode (
        .i_clk            (i_clk),
        .quick_n_reset    (quick_n_reset),
        .i_ireq           (i_icache_req),
        .i_iqword         (i_icache_qword),
        .i_iaddr          (i_icache_address),
        .i_dreq           (i_dcache_req),
        .i_dwrite         (i_dcache_write),
        .i_dqword         (i_dcache_qword),
        .i_daddr          (i_dcache_address),
        .i_dwdata         (i_dcache_write_data),
        .i_dsel           (i_dcache_byte_enable),
        .i_busy           (busy),
        .i_ipending_clear (ipending_clear),
        .i_dpending_clear (dpending_clear),
        .o_cmd            (cmd)
    );

    // bus cycle FSM
    wb_bus_execute u_execute (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .i_cmd         (cmd),
        .i_wb_ack      (i_wb_ack),
        .i_wb_dat      (i_wb_dat),
        .o_busy        (busy),
        .o_port        (port),
        .o_word_ack    (word_ack),
        .o_last_ack    (last_ack),
        .o_rdata       (rdata),
        .o_wb_adr      (o_wb_adr),
        .o_wb_sel      (o_wb_sel),
        .o_wb_we       (o_wb_we),
        .o_wb_dat      (o_wb_dat),
        .o_wb_cyc      (o_wb_cyc),
        .o_wb_stb      (o_wb_stb)
    );

    // read data and done handshake back to the caches
    wb_resp_route u_route (
        .i_clk            (i_clk),
        .quick_n_reset    (quick_n_reset),
        .i_port           (port),
        .i_word_ack       (word_ack),
        .i_last_ack       (last_ack),
        .i_rdata          (rdata),
        .i_ireq           (i_icache_req),
        .i_dreq           (i_dcache_req),
        .o_irvalid        (o_icache_rvalid),
        .o_irdata         (o_icache_read_data),
        .o_idone          (o_icache_done),
        .o_drvalid        (o_dcache_rvalid),
        .o_drdata         (o_dcache_read_data),
        .o_ddone          (o_dcache_done),
        .o_ipending_clear (ipending_clear),
        .o_dpending_clear (dpending_clear)
    );

endmodule

/* tb_wb_master.sv */
module tb_wb_master
    import cache_req_pkg::*;
();

    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 16;
    localparam int N_ENTRIES  = 18;

    // kinds of table entry
    // the last one raises both requests together
    localparam logic [1:0] K_INSTR = 2'd0;
    localparam logic [1:0] K_DATA  = 2'd1;
    localparam logic [1:0] K_BOTH  = 2'd2;

    // one table row
    // exp[i] is the i-th word returned to the port
    // lsb is the low address pair the slave must see on a write
    typedef struct packed
    {
        logic [1:0]       kind;
        logic             write;
        logic             qword;
        logic [31:0]      addr;
        logic [3:0]       sel;
        logic [31:0]      wdata;
        logic [1:0]       lsb;
        logic [31:0]      iaddr;
        logic [31:0]      iword;
        logic [3:0][31:0] exp;
    } stim_t;

    logic        clk;
    logic        quick_n_reset;
    logic        icache_req;
    logic        icache_qword;
    logic [31:0] icache_address;
    logic        icache_rvalid;
    logic [31:0] icache_rdata;
    logic        icache_done;
    logic        dcache_req;
    logic        dcache_write;
    logic        dcache_qword;
    logic [31:0] dcache_address;
    logic [31:0] dcache_wdata;
    logic [3:0]  dcache_sel;
    logic        dcache_rvalid;
    logic [31:0] dcache_rdata;
    logic        dcache_done;
    logic [31:0] wb_adr;
    logic [3:0]  wb_sel;
    logic        wb_we;
    logic [31:0] wb_wdat;
    logic        wb_cyc;
    logic        wb_stb;
    logic [31:0] wb_rdat = '0;
    logic        wb_ack  = 1'b0;
    logic        bus_req;

    logic [31:0] mem [64];
    stim_t       stim [$];
    logic [31:0] bus_starts [$];
    int          seed = 58;
    int          wait_left;
    int          beats;
    logic        stb_d;
    int          err_data;
    int          err_bus;
    int          err_proto;
    time         idone_at;
    time         ddone_at;

    wb_master i_wb_master (
        .i_clk                (clk),
        .quick_n_reset        (quick_n_reset),
        .i_icache_req         (icache_req),
        .i_icache_qword       (icache_qword),
        .i_icache_address     (icache_address),
        .o_icache_rvalid      (icache_rvalid),
        .o_icache_read_data   (icache_rdata),
        .o_icache_done        (icache_done),
        .i_dcache_req         (dcache_req),
        .i_dcache_write       (dcache_write),
        .i_dcache_qword       (dcache_qword),
        .i_dcache_address     (dcache_address),
        .i_dcache_write_data  (dcache_wdata),
        .i_dcache_byte_enable (dcache_sel),
        .o_dcache_rvalid      (dcache_rvalid),
        .o_dcache_read_data   (dcache_rdata),
        .o_dcache_done        (dcache_done),
        .o_wb_adr             (wb_adr),
        .o_wb_sel             (wb_sel),
        .o_wb_we              (wb_we),
        .o_wb_dat             (wb_wdat),
        .o_wb_cyc             (wb_cyc),
        .o_wb_stb             (wb_stb),
        .i_wb_dat             (wb_rdat),
        .i_wb_ack             (wb_ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // every byte lane of every word differs, so a wrong lane or word shows up
    function automatic logic [31:0] fill_word(input int i);
        logic [7:0] w;
        w = 8'(i);
        return {8'hA0 + w, 8'h50 + w, 8'h30 + w, 8'h10 + w};
    endfunction

    // ==================================================
    // wishbone slave model
    // ==================================================

    // the slave only answers a strobe that sits inside a bus cycle
    assign bus_req = wb_cyc && wb_stb;

    // the registered ack follows 0 to 3 wait cycles and is high for one cycle
    // the first address of each bus cycle is logged for the address checks
    always @(posedge clk)
    begin
        if (!quick_n_reset)
        begin
            wb_ack    <= 1'b0;
            wait_left <= 0;
            beats     <= 0;
            stb_d     <= 1'b0;
            for (int i = 0; i < 64; i++)
                mem[i] <= fill_word(i);
        end
        else
        begin
            stb_d <= bus_req;
            if (bus_req && !stb_d)
                bus_starts.push_back(wb_adr);
            if (wb_ack)
            begin
                wb_ack    <= 1'b0;
                wait_left <= $unsigned($random(seed)) % 4;
            end
            else if (bus_req && wait_left > 0)
            begin
                wait_left <= wait_left - 1;
            end
            else if (bus_req)
            begin
                wb_ack <= 1'b1;
                beats  <= beats + 1;
                if (wb_we)
                begin
                    for (int b = 0; b < 4; b++)
                        if (wb_sel[b])
                            mem[wb_adr[7:2]][8*b +: 8] <= wb_wdat[8*b +: 8];
                end
                else
                begin
                    wb_rdat <= mem[wb_adr[7:2]];
                end
            end
        end
    end

    // ==================================================
    // stimulus table
    // ==================================================

    function automatic void add_read(input logic [1:0] kind, input logic qword,
                                     input logic [31:0] addr, input logic [31:0] e0,
                                     input logic [31:0] e1, input logic [31:0] e2,
                                     input logic [31:0] e3);
        stim_t s;
        s       = '0;
        s.kind  = kind;
        s.qword = qword;
        s.addr  = addr;
        s.exp   = {e3, e2, e1, e0};
        stim.push_back(s);
    endfunction

    function automatic void add_write(input logic [31:0] addr, input logic [3:0] sel,
                                      input logic [31:0] wdata, input logic [1:0] lsb);
        stim_t s;
        s       = '0;
        s.kind  = K_DATA;
        s.write = 1'b1;
        s.addr  = addr;
        s.sel   = sel;
        s.wdata = wdata;
        s.lsb   = lsb;
        stim.push_back(s);
    endfunction

    function automatic void add_both(input logic [31:0] daddr, input logic [31:0] dword,
                                     input logic [31:0] iaddr, input logic [31:0] iword);
        stim_t s;
        s        = '0;
        s.kind   = K_BOTH;
        s.addr   = daddr;
        s.exp[0] = dword;
        s.iaddr  = iaddr;
        s.iword  = iword;
        stim.push_back(s);
    endfunction

    // single reads come first and then line fills that start inside the line
    // the writes walk over the byte enable patterns and are read back
    function automatic void load_table();
        add_read(K_INSTR, 1'b0, 32'h14, 32'hA5553515, '0, '0, '0);
        add_read(K_DATA, 1'b0, 32'h22, 32'hA8583818, '0, '0, '0);
        add_read(K_INSTR, 1'b1, 32'h48, 32'hB2624222, 32'hB3634323,
                 32'hB0604020, 32'hB1614121);
        add_read(K_DATA, 1'b1, 32'h84, 32'hC1715131, 32'hC2725232,
                 32'hC3735333, 32'hC0705030);
        add_write(32'hA3, 4'b0001, 32'h11223344, 2'd0);
        add_write(32'hA0, 4'b0100, 32'h55667788, 2'd2);
        add_read(K_DATA, 1'b0, 32'hA0, 32'hC8665844, '0, '0, '0);
        add_write(32'hA4, 4'b0010, 32'hDEADBEEF, 2'd1);
        add_write(32'hA6, 4'b1000, 32'h0BADF00D, 2'd3);
        add_read(K_DATA, 1'b0, 32'hA4, 32'h0B79BE39, '0, '0, '0);
        add_write(32'hA8, 4'b0011, 32'h12345678, 2'd0);
        add_read(K_DATA, 1'b0, 32'hA8, 32'hCA7A5678, '0, '0, '0);
        add_write(32'hAC, 4'b1100, 32'h9ABCDEF0, 2'd2);
        add_write(32'hAD, 4'b0101, 32'hFFFFFFFF, 2'd0);
        add_read(K_DATA, 1'b0, 32'hAC, 32'h9AFF5BFF, '0, '0, '0);
        add_write(32'hB0, 4'b1111, 32'hCAFEF00D, 2'd0);
        add_read(K_INSTR, 1'b0, 32'hB0, 32'hCAFEF00D, '0, '0, '0);
        add_both(32'h10, 32'hA4543414, 32'h0C, 32'hA3533313);
    endfunction

    // first bus address of an access
    // on writes the low bits come from the byte enables
    function automatic logic [31:0] bus_addr(input stim_t s);
        if (s.write)
            return {s.addr[31:2], s.lsb};
        return {s.addr[31:2], 2'b00};
    endfunction

    // ==================================================
    // four-phase port drivers
    // ==================================================

    task automatic fetch_instr(input logic [31:0] addr, input logic qword,
                               input logic [3:0][31:0] exp);
        int got;
        int want;
        got  = 0;
        want = qword ? BURST_WORDS : 1;
        @(posedge clk);
        icache_req     <= 1'b1;
        icache_qword   <= qword;
        icache_address <= addr;
        do
        begin
            @(negedge clk);
            if (icache_rvalid)
            begin
                if (got < want && icache_rdata !== exp[got])
                begin
                    $display("ERR %0t icache_read_data exp %h got %h",
                             $time, exp[got], icache_rdata);
                    err_data++;
                end
                got++;
            end
        end
        while (!icache_done);
        idone_at = $time;
        if (got != want)
        begin
            $display("instruction port got %0d words instead of %0d", got, want);
            err_proto++;
        end
        @(posedge clk);
        icache_req <= 1'b0;
        @(negedge clk);
        if (!icache_done)
        begin
            $display("instruction done fell before its request dropped");
            err_proto++;
        end
        while (icache_done)
            @(negedge clk);
    endtask

    task automatic access_data(input stim_t s);
        int got;
        int want;
        got  = 0;
        want = s.write ? 0 : (s.qword ? BURST_WORDS : 1);
        @(posedge clk);
        dcache_req     <= 1'b1;
        dcache_write   <= s.write;
        dcache_qword   <= s.qword;
        dcache_address <= s.addr;
        dcache_wdata   <= s.wdata;
        dcache_sel     <= s.sel;
        do
        begin
            @(negedge clk);
            if (dcache_rvalid)
            begin
                if (got < want && dcache_rdata !== s.exp[got])
                begin
                    $display("ERR %0t dcache_read_data exp %h got %h",
                             $time, s.exp[got], dcache_rdata);
                    err_data++;
                end
                got++;
            end
        end
        while (!dcache_done);
        ddone_at = $time;
        if (got != want)
        begin
            $display("data port got %0d words instead of %0d", got, want);
            err_proto++;
        end
        @(posedge clk);
        dcache_req <= 1'b0;
        @(negedge clk);
        if (!dcache_done)
        begin
            $display("data done fell before its request dropped");
            err_proto++;
        end
        while (dcache_done)
            @(negedge clk);
    endtask

    // ==================================================
    // main sequence
    // ==================================================

    initial
    begin
        stim_t s;
        int    exp_beats;
        exp_beats      = 0;
        err_data       = 0;
        err_bus        = 0;
        err_proto      = 0;
        quick_n_reset  = 1'b0;
        icache_req     = 1'b0;
        icache_qword   = 1'b0;
        icache_address = '0;
        dcache_req     = 1'b0;
        dcache_write   = 1'b0;
        dcache_qword   = 1'b0;
        dcache_address = '0;
        dcache_wdata   = '0;
        dcache_sel     = '0;
        load_table();
        repeat (RST_CYCLES) @(posedge clk);
        quick_n_reset <= 1'b1;
        @(negedge clk);
        if ((wb_cyc | wb_stb | wb_we | icache_done | dcache_done
             | icache_rvalid | dcache_rvalid) !== 1'b0)
        begin
            $display("bus or handshake outputs are not low after reset");
            err_proto++;
        end

        for (int n = 0; n < stim.size(); n++)
        begin
            s = stim[n];
            bus_starts.delete();
            if (s.kind == K_INSTR)
            begin
                fetch_instr(s.addr, s.qword, s.exp);
            end
            else if (s.kind == K_DATA)
            begin
                access_data(s);
            end
            else
            begin
                fork
                    access_data(s);
                    fetch_instr(s.iaddr, 1'b0, {96'h0, s.iword});
                join
                if (ddone_at >= idone_at)
                begin
                    $display("data done did not rise before instruction done");
                    err_proto++;
                end
            end
            if (s.kind == K_BOTH)
                exp_beats += 2;
            else
                exp_beats += s.qword ? BURST_WORDS : 1;
            // the first cycle of a two port entry belongs to the data port
            if (bus_starts.size() == 0)
            begin
                $display("entry %0d never started a bus cycle", n);
                err_bus++;
            end
            else if (bus_starts[0] !== bus_addr(s))
            begin
                $display("ERR %0t o_wb_adr exp %h got %h", $time, bus_addr(s), bus_starts[0]);
                err_bus++;
            end
        end

        repeat (4) @(negedge clk);
        if (beats != exp_beats)
        begin
            $display("slave saw %0d bus beats instead of %0d", beats, exp_beats);
            err_proto++;
        end
        $display("errors: data %0d, bus %0d, protocol %0d", err_data, err_bus, err_proto);
        if (err_data + err_bus + err_proto == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    // allows 40 cycles per table entry on top of the reset time
    initial
    begin
        #((RST_CYCLES + N_ENTRIES * 40) * CLK_PERIOD);
        $display("timeout: the table did not finish within %0d cycles",
                 RST_CYCLES + N_ENTRIES * 40);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* files.f */
wb_bus_pkg.sv
cache_req_pkg.sv
wb_req_decode.sv
wb_bus_execute.sv
wb_resp_route.sv
wb_master.sv
tb_wb_master.sv

/* run_sim.sh */
#!/bin/sh
# builds the wishbone master testbench with verilator and runs it
# the run passes only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -f files.f --top-module tb_wb_master -o sim_wb_master; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/sim_wb_master > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error status"
    exit 1
fi

cat sim.log
if grep -q '^\*\* PASS \*\*$' sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
